/* hw/scope_pkg.sv */
//////////////////////////////////////////////////////////////////////
// scope package
// shared widths, sample type, register map and trigger indices
//////////////////////////////////////////////////////////////////////

`default_nettype none

package scope_pkg;

  // sample stream
  localparam int unsigned dw    = 14;
  typedef logic signed [dw-1:0] dat_t;

  // decimator
  localparam int unsigned dcw   = 17;        // decimation counter
  localparam int unsigned dsw   = 4;         // shift amount
  localparam int unsigned sum_w = dw + dcw;  // room for a full window sum

  // acquisition
  localparam int unsigned cw    = 17;        // pre/post counters
  localparam int unsigned tw    = 64;        // timestamp
  localparam int unsigned tn    = 4;         // trigger sources

  // bus
  localparam int unsigned baw   = 7;
  localparam int unsigned bdw   = 32;

  // trigger vector layout
  localparam int unsigned trg_sw_bit   = 0;
  localparam int unsigned trg_edge_bit = 1;
  localparam int unsigned trg_ext_lo   = 2;  // two external inputs from here

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////
  localparam logic [baw-1:0] reg_ctl     = 7'h00;
  localparam logic [baw-1:0] reg_mode    = 7'h04;
  localparam logic [baw-1:0] reg_trg     = 7'h08;
  localparam logic [baw-1:0] reg_pre     = 7'h10;
  localparam logic [baw-1:0] reg_pst     = 7'h14;
  localparam logic [baw-1:0] reg_sts_pre = 7'h18;  // read only
  localparam logic [baw-1:0] reg_sts_pst = 7'h1c;  // read only
  localparam logic [baw-1:0] reg_cts_lo  = 7'h28;
  localparam logic [baw-1:0] reg_cts_hi  = 7'h2c;
  localparam logic [baw-1:0] reg_lvl     = 7'h50;
  localparam logic [baw-1:0] reg_hst     = 7'h54;
  localparam logic [baw-1:0] reg_edg     = 7'h58;
  localparam logic [baw-1:0] reg_avg     = 7'h60;
  localparam logic [baw-1:0] reg_dec     = 7'h64;
  localparam logic [baw-1:0] reg_shr     = 7'h68;

endpackage

`default_nettype wire

/* hw/scope_regs.sv */
//////////////////////////////////////////////////////////////////////
// scope register bank
// config registers, control pulses and status readback on the bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scope_regs (
  input  logic                        bus,
  input  logic                        rst,
  // bus
  input  logic                        bus_wen,
  input  logic                        bus_ren,
  input  logic [scope_pkg::bdw-1:0]   bus_addr,
  input  logic [scope_pkg::bdw-1:0]   bus_wdata,
  output logic [scope_pkg::bdw-1:0]   bus_rdata,
  output logic                        bus_ack,
  // status from acquisition
  input  logic                        sts_acq,
  input  logic                        sts_trg,
  input  logic [scope_pkg::cw-1:0]    sts_pre,
  input  logic [scope_pkg::cw-1:0]    sts_pst,
  input  logic [scope_pkg::tw-1:0]    cts_trg,
  // control pulses
  output logic                        ctl_rst,
  output logic                        ctl_acq,
  output logic                        ctl_stp,
  output logic                        trg_swo,
  // configuration
  output logic                        cfg_con,
  output logic [scope_pkg::tn-1:0]    cfg_trg,
  output logic [scope_pkg::cw-1:0]    cfg_pre,
  output logic [scope_pkg::cw-1:0]    cfg_pst,
  output scope_pkg::dat_t             cfg_lvl,
  output logic [scope_pkg::dw-1:0]    cfg_hst,
  output logic                        cfg_edg,
  output logic                        cfg_avg,
  output logic [scope_pkg::dcw-1:0]   cfg_dec,
  output logic [scope_pkg::dsw-1:0]   cfg_shr
);

  logic [scope_pkg::baw-1:0] adr;  // decoded low address bits
  logic                      ctl_wr;

  assign adr    = bus_addr[scope_pkg::baw-1:0];
  assign ctl_wr = bus_wen && (adr == scope_pkg::reg_ctl);

  // pulses live only in the write cycle
  assign ctl_rst = ctl_wr & bus_wdata[0];
  assign trg_swo = ctl_wr & bus_wdata[1];
  assign ctl_acq = ctl_wr & bus_wdata[2];
  assign ctl_stp = ctl_wr & bus_wdata[3];

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge bus) begin
    if (rst) begin
      cfg_con <= 1'b0;
      cfg_trg <= '0;
      cfg_pre <= '0;
      cfg_pst <= '0;
      cfg_lvl <= '0;
      cfg_hst <= '0;
      cfg_edg <= 1'b0;
      cfg_avg <= 1'b0;
      cfg_dec <= '0;
      cfg_shr <= '0;
    end else if (bus_wen) begin
      case (adr)
        scope_pkg::reg_mode: cfg_con <= bus_wdata[0];
        scope_pkg::reg_trg:  cfg_trg <= bus_wdata[scope_pkg::tn-1:0];
        scope_pkg::reg_pre:  cfg_pre <= bus_wdata[scope_pkg::cw-1:0];
        scope_pkg::reg_pst:  cfg_pst <= bus_wdata[scope_pkg::cw-1:0];
        scope_pkg::reg_lvl:  cfg_lvl <= bus_wdata[scope_pkg::dw-1:0];
        scope_pkg::reg_hst:  cfg_hst <= bus_wdata[scope_pkg::dw-1:0];
        scope_pkg::reg_edg:  cfg_edg <= bus_wdata[0];   // 0 rising, 1 falling
        scope_pkg::reg_avg:  cfg_avg <= bus_wdata[0];
        scope_pkg::reg_dec:  cfg_dec <= bus_wdata[scope_pkg::dcw-1:0];
        scope_pkg::reg_shr:  cfg_shr <= bus_wdata[scope_pkg::dsw-1:0];
        default: ;                                      // ctl and status ignored
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side and acknowledge
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge bus) begin
    if (rst) bus_ack <= 1'b0;
    else     bus_ack <= bus_wen | bus_ren;  // one cycle after any strobe
  end

  always_ff @(posedge bus) begin
    if (bus_ren) begin
      bus_rdata <= '0;  // zero fill so unmapped reads 0
      case (adr)
        scope_pkg::reg_ctl:     bus_rdata[3:0] <= {~sts_acq, sts_acq, sts_trg, 1'b0};
        scope_pkg::reg_mode:    bus_rdata[0] <= cfg_con;
        scope_pkg::reg_trg:     bus_rdata[scope_pkg::tn-1:0] <= cfg_trg;
        scope_pkg::reg_pre:     bus_rdata[scope_pkg::cw-1:0] <= cfg_pre;
        scope_pkg::reg_pst:     bus_rdata[scope_pkg::cw-1:0] <= cfg_pst;
        scope_pkg::reg_sts_pre: bus_rdata[scope_pkg::cw-1:0] <= sts_pre;
        scope_pkg::reg_sts_pst: bus_rdata[scope_pkg::cw-1:0] <= sts_pst;
        scope_pkg::reg_cts_lo:  bus_rdata <= cts_trg[scope_pkg::bdw-1:0];
        scope_pkg::reg_cts_hi:  bus_rdata <= cts_trg[scope_pkg::tw-1:scope_pkg::bdw];
        scope_pkg::reg_lvl:     bus_rdata[scope_pkg::dw-1:0] <= cfg_lvl;
        scope_pkg::reg_hst:     bus_rdata[scope_pkg::dw-1:0] <= cfg_hst;
        scope_pkg::reg_edg:     bus_rdata[0] <= cfg_edg;
        scope_pkg::reg_avg:     bus_rdata[0] <= cfg_avg;
        scope_pkg::reg_dec:     bus_rdata[scope_pkg::dcw-1:0] <= cfg_dec;
        scope_pkg::reg_shr:     bus_rdata[scope_pkg::dsw-1:0] <= cfg_shr;
        default: ;
      endcase
    end
  end

  // each ack answers a single write or a single read
  a_ack_one_strobe: assert property (
    @(posedge bus) disable iff (rst) bus_ack |-> $past(bus_wen) != $past(bus_ren)
  );

endmodule

`default_nettype wire

/* hw/scope_dec_avg.sv */
//////////////////////////////////////////////////////////////////////
// decimator with optional window averaging
// keeps one sample per window, or the window sum shifted right
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scope_dec_avg (
  input  logic                        bus,
  input  logic                        rst,
  input  logic                        ctl_rst,
  input  logic                        cfg_avg,
  input  logic [scope_pkg::dcw-1:0]   cfg_dec,
  input  logic [scope_pkg::dsw-1:0]   cfg_shr,
  input  scope_pkg::dat_t             adc_dat,
  input  logic                        adc_vld,
  output scope_pkg::dat_t             dec_dat,
  output logic                        dec_vld
);

  logic [scope_pkg::dcw-1:0]          cnt;      // position in window
  logic                               win_end;  // last sample of window
  logic signed [scope_pkg::sum_w-1:0] sum;
  logic signed [scope_pkg::sum_w-1:0] acc_in;
  logic signed [scope_pkg::sum_w-1:0] sum_nxt;

  assign win_end = (cnt >= cfg_dec);  // >= so a smaller cfg_dec still wraps

  // first sample of a window starts from zero
  assign acc_in  = (cnt == '0) ? '0 : sum;
  assign sum_nxt = acc_in + scope_pkg::sum_w'(adc_dat);  // sign extended

  // window counter and output strobe
  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      cnt     <= '0;
      dec_vld <= 1'b0;
    end else begin
      dec_vld <= adc_vld & win_end;
      if (adc_vld) begin
        cnt <= win_end ? '0 : cnt + 1'b1;
      end
    end
  end

  // accumulator and output sample
  always_ff @(posedge bus) begin
    if (adc_vld) begin
      sum <= sum_nxt;
      if (win_end) begin
        dec_dat <= cfg_avg ? scope_pkg::dat_t'(sum_nxt >>> cfg_shr) : adc_dat;
      end
    end
  end

  // counter stays inside the window while cfg_dec holds
  a_cnt_in_window: assert property (
    @(posedge bus) disable iff (rst)
    adc_vld ##1 $stable(cfg_dec) |-> cnt <= cfg_dec
  );

endmodule

`default_nettype wire

/* hw/scope_edge.sv */
//////////////////////////////////////////////////////////////////////
// level crossing trigger
// schmitt style detector with hysteresis and edge select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scope_edge (
  input  logic                        bus,
  input  logic                        rst,
  input  logic                        ctl_rst,
  input  logic                        cfg_edg,  // 0 rising, 1 falling
  input  scope_pkg::dat_t             cfg_lvl,
  input  logic [scope_pkg::dw-1:0]    cfg_hst,
  input  scope_pkg::dat_t             dec_dat,
  input  logic                        dec_vld,
  output logic                        trg_out
);

  // two extra bits so level +- hysteresis cannot wrap
  logic signed [scope_pkg::dw+1:0] lvl;
  logic signed [scope_pkg::dw+1:0] hst;
  logic signed [scope_pkg::dw+1:0] dat;
  logic                            armed;

  assign lvl = cfg_lvl;
  assign hst = signed'({2'b00, cfg_hst});
  assign dat = dec_dat;

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      armed   <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;  // single cycle pulse
      if (dec_vld) begin
        if (!cfg_edg) begin
          if (armed && dat >= lvl) begin
            trg_out <= 1'b1;
            armed   <= 1'b0;
          end else if (dat < lvl - hst) begin
            armed <= 1'b1;  // went below band, arm
          end
        end else begin
          if (armed && dat <= lvl) begin
            trg_out <= 1'b1;
            armed   <= 1'b0;
          end else if (dat > lvl + hst) begin
            armed <= 1'b1;  // mirrored for falling edge
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/scope_acq.sv */
//////////////////////////////////////////////////////////////////////
// acquisition control
// pre/post trigger counting, trigger timestamp, irqs, output gate
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scope_acq (
  input  logic                        bus,
  input  logic                        rst,
  input  logic                        ctl_rst,
  input  logic                        ctl_acq,
  input  logic                        ctl_stp,
  input  logic                        cfg_con,  // continuous, no auto stop
  input  logic [scope_pkg::tn-1:0]    cfg_trg,
  input  logic [scope_pkg::cw-1:0]    cfg_pre,
  input  logic [scope_pkg::cw-1:0]    cfg_pst,
  input  logic [scope_pkg::tn-1:0]    trg_src,
  input  logic [scope_pkg::tw-1:0]    cts,
  input  scope_pkg::dat_t             dec_dat,
  input  logic                        dec_vld,
  output scope_pkg::dat_t             sto_dat,
  output logic                        sto_vld,
  output logic                        sto_lst,
  output logic                        sts_acq,
  output logic                        sts_trg,
  output logic [scope_pkg::cw-1:0]    sts_pre,
  output logic [scope_pkg::cw-1:0]    sts_pst,
  output logic [scope_pkg::tw-1:0]    cts_trg,
  output logic                        irq_trg,
  output logic                        irq_stp
);

  logic pre_done;  // enough pre-trigger samples
  logic trg_hit;   // trigger accepted this cycle
  logic pst_end;   // last post-trigger sample

  assign pre_done = (sts_pre >= cfg_pre);
  assign trg_hit  = sts_acq && !sts_trg && pre_done && |(trg_src & cfg_trg)
                    && !ctl_acq && !ctl_rst;
  assign pst_end  = sts_acq && sts_trg && dec_vld && !cfg_con
                    && (sts_pst + 1'b1 >= cfg_pst);

  // output is a plain gate, no added latency
  assign sto_dat = dec_dat;
  assign sto_vld = dec_vld & sts_acq;
  assign sto_lst = pst_end;

  //////////////////////////////////////////////////////////////////////
  // acquisition state
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
    end else begin
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
      if (ctl_acq) begin  // (re)start
        sts_acq <= 1'b1;
        sts_trg <= 1'b0;
        sts_pre <= '0;
        sts_pst <= '0;
      end else if (sts_acq) begin
        if (ctl_stp || pst_end) begin
          sts_acq <= 1'b0;
          irq_stp <= 1'b1;
        end
        if (trg_hit) begin
          sts_trg <= 1'b1;
          irq_trg <= 1'b1;
        end
        if (dec_vld) begin
          if (sts_trg) sts_pst <= sts_pst + 1'b1;
          else if (!pre_done) sts_pre <= sts_pre + 1'b1;  // saturates at cfg_pre
        end
      end
    end
  end

  // timestamp of the accepted trigger
  always_ff @(posedge bus) begin
    if (trg_hit) cts_trg <= cts;
  end

  // triggered state only ever comes from an accepted trigger
  a_trg_accepted: assert property (
    @(posedge bus) disable iff (rst) $rose(sts_trg) |-> $past(trg_hit) && irq_trg
  );

endmodule

`default_nettype wire

/* hw/scope_top.sv */
//////////////////////////////////////////////////////////////////////
// scope channel top level
// register bank, decimator, edge trigger and acquisition control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scope_top (
  input  logic                        bus,
  input  logic                        rst,
  // bus
  input  logic                        bus_wen,
  input  logic                        bus_ren,
  input  logic [scope_pkg::bdw-1:0]   bus_addr,
  input  logic [scope_pkg::bdw-1:0]   bus_wdata,
  output logic [scope_pkg::bdw-1:0]   bus_rdata,
  output logic                        bus_ack,
  // adc stream in, samples out
  input  scope_pkg::dat_t             adc_dat,
  input  logic                        adc_vld,
  output scope_pkg::dat_t             sto_dat,
  output logic                        sto_vld,
  output logic                        sto_lst,
  // time and triggers
  input  logic [scope_pkg::tw-1:0]    cts,
  input  logic [1:0]                  trg_ext,
  output logic                        trg_out,
  output logic                        trg_swo,
  output logic                        irq_trg,
  output logic                        irq_stp
);

  logic                      ctl_rst, ctl_acq, ctl_stp;
  logic                      cfg_con, cfg_edg, cfg_avg;
  logic [scope_pkg::tn-1:0]  cfg_trg;
  logic [scope_pkg::cw-1:0]  cfg_pre, cfg_pst;
  scope_pkg::dat_t           cfg_lvl;
  logic [scope_pkg::dw-1:0]  cfg_hst;
  logic [scope_pkg::dcw-1:0] cfg_dec;
  logic [scope_pkg::dsw-1:0] cfg_shr;
  logic                      sts_acq, sts_trg;
  logic [scope_pkg::cw-1:0]  sts_pre, sts_pst;
  logic [scope_pkg::tw-1:0]  cts_trg;
  scope_pkg::dat_t           dec_dat;    // decimated stream
  logic                      dec_vld;
  logic [scope_pkg::tn-1:0]  trg_src;    // all trigger sources

  assign trg_src[scope_pkg::trg_sw_bit]     = trg_swo;
  assign trg_src[scope_pkg::trg_edge_bit]   = trg_out;
  assign trg_src[scope_pkg::trg_ext_lo +: 2] = trg_ext;

  scope_regs i_scope_regs (
    .bus, .rst, .bus_wen, .bus_ren, .bus_addr, .bus_wdata, .bus_rdata, .bus_ack,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_trg,
    .ctl_rst, .ctl_acq, .ctl_stp, .trg_swo,
    .cfg_con, .cfg_trg, .cfg_pre, .cfg_pst, .cfg_lvl, .cfg_hst, .cfg_edg,
    .cfg_avg, .cfg_dec, .cfg_shr
  );

  scope_dec_avg i_scope_dec_avg (
    .bus, .rst, .ctl_rst, .cfg_avg, .cfg_dec, .cfg_shr,
    .adc_dat, .adc_vld, .dec_dat, .dec_vld
  );

  scope_edge i_scope_edge (
    .bus, .rst, .ctl_rst, .cfg_edg, .cfg_lvl, .cfg_hst, .dec_dat, .dec_vld, .trg_out
  );

  scope_acq i_scope_acq (
    .bus, .rst, .ctl_rst, .ctl_acq, .ctl_stp, .cfg_con, .cfg_trg, .cfg_pre, .cfg_pst,
    .trg_src, .cts, .dec_dat, .dec_vld,
    .sto_dat, .sto_vld, .sto_lst, .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_trg,
    .irq_trg, .irq_stp
  );

endmodule

`default_nettype wire

/* tests/scope_tb.sv */
//////////////////////////////////////////////////////////////////////
// scope channel testbench
// directed tests for registers, decimation, triggers and acquisition
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scope_tb;

  logic                          bus, rst;
  logic                          bus_wen, bus_ren, bus_ack;
  logic [scope_pkg::bdw-1:0]     bus_addr, bus_wdata, bus_rdata;
  scope_pkg::dat_t               adc_dat, sto_dat;
  logic                          adc_vld, sto_vld, sto_lst;
  logic [scope_pkg::tw-1:0]      cts;
  logic [1:0]                    trg_ext;
  logic                          trg_out, trg_swo, irq_trg, irq_stp;

  int              errors = 0;
  int              n_tests = 0;
  int              seed = 59;
  int              n_trg = 0;      // trg_out pulses seen
  int              n_swo = 0;      // trg_swo pulses seen
  int              n_irq_trg = 0;
  int              n_irq_stp = 0;
  int              n_lst = 0;
  scope_pkg::dat_t out_q[$];       // every sto_dat with sto_vld
  logic            lst_q[$];       // sto_lst next to it
  scope_pkg::dat_t stim_q[$];      // samples of the running test

  scope_top i_scope_top (.*);

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;  // 4 ns period
  end

  always @(posedge bus) cts <= cts + 1'b1;  // free running time

  // output monitor sampled away from the active edge
  always @(negedge bus) begin
    if (sto_vld === 1'b1) begin
      out_q.push_back(sto_dat);
      lst_q.push_back(sto_lst);
    end
    if (sto_vld === 1'b1 && sto_lst === 1'b1) n_lst++;
    if (trg_out === 1'b1) n_trg++;
    if (trg_swo === 1'b1) n_swo++;
    if (irq_trg === 1'b1) n_irq_trg++;
    if (irq_stp === 1'b1) n_irq_stp++;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting and bus tasks
  //////////////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [63:0] got, exp);
    $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_fail(input string msg);
    $display("failure at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic test_done(input string name, input int err0);
    n_tests++;
    if (errors == err0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err0);
  endtask

  task automatic wait_ack(output logic [31:0] rd);
    int n;
    n = 0;
    @(posedge bus);
    bus_wen <= 1'b0;  // strobes last one cycle
    bus_ren <= 1'b0;
    do begin
      @(negedge bus);
      n++;
    end while (bus_ack !== 1'b1 && n < 16);
    if (bus_ack !== 1'b1) report_fail("bus_ack never came");
    rd = bus_rdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    @(posedge bus);
    bus_addr  <= addr;
    bus_wdata <= data;
    bus_wen   <= 1'b1;
    wait_ack(unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rd);
    @(posedge bus);
    bus_addr <= addr;
    bus_ren  <= 1'b1;
    wait_ack(rd);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    bus_read(addr, rd);
    if (rd !== exp) report_mismatch(name, rd, exp);
  endtask

  // one sample per cycle then let the one cycle datapath latency drain
  task automatic feed_stim();
    foreach (stim_q[i]) begin
      @(posedge bus);
      adc_dat <= stim_q[i];
      adc_vld <= 1'b1;
    end
    @(posedge bus);
    adc_vld <= 1'b0;
    repeat (3) @(posedge bus);
  endtask

  task automatic fill_random(input int n);
    stim_q.delete();
    repeat (n) stim_q.push_back(scope_pkg::dat_t'($random(seed)));
  endtask

  // clear datapath, load config, start acquiring
  task automatic setup(input logic con, input logic [3:0] trg, input int pre, pst, dec,
                       input logic avg, input int shr);
    bus_write(scope_pkg::reg_ctl, 32'h1);
    bus_write(scope_pkg::reg_mode, con);
    bus_write(scope_pkg::reg_trg, trg);
    bus_write(scope_pkg::reg_pre, pre);
    bus_write(scope_pkg::reg_pst, pst);
    bus_write(scope_pkg::reg_dec, dec);
    bus_write(scope_pkg::reg_avg, avg);
    bus_write(scope_pkg::reg_shr, shr);
    bus_write(scope_pkg::reg_ctl, 32'h4);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic test_registers();
    int          err0;
    logic [31:0] v;
    logic [31:0] cfg_addr[10];
    logic [31:0] rnd_addr[3];
    logic [31:0] rnd_mask[3];
    err0 = errors;
    cfg_addr = '{scope_pkg::reg_mode, scope_pkg::reg_trg, scope_pkg::reg_pre,
                 scope_pkg::reg_pst, scope_pkg::reg_lvl, scope_pkg::reg_hst,
                 scope_pkg::reg_edg, scope_pkg::reg_avg, scope_pkg::reg_dec,
                 scope_pkg::reg_shr};
    rnd_addr = '{scope_pkg::reg_lvl, scope_pkg::reg_dec, scope_pkg::reg_pre};
    rnd_mask = '{32'h3fff, 32'h1ffff, 32'h1ffff};  // 14, 17 and 17 bits
    foreach (cfg_addr[i]) read_expect(cfg_addr[i], 32'h0, "config after reset");
    read_expect(scope_pkg::reg_ctl, 32'h8, "ctl status");  // not acquiring only
    foreach (rnd_addr[i]) begin
      v = $random(seed);
      bus_write(rnd_addr[i], v);
      read_expect(rnd_addr[i], v & rnd_mask[i], "config readback");
    end
    read_expect(32'h30, 32'h0, "unmapped read");
    test_done("registers", err0);
  endtask

  task automatic test_decimate(input logic avg);
    int err0, base, s;
    scope_pkg::dat_t exp;
    err0 = errors;
    setup(1'b1, 4'b0000, 0, 0, 3, avg, 2);  // continuous mode with no trigger source
    fill_random(16);
    base = out_q.size();
    feed_stim();
    if (out_q.size() - base != 4) begin
      report_mismatch("sto_vld count", out_q.size() - base, 4);
    end else begin
      for (int w = 0; w < 4; w++) begin
        s = 0;
        for (int k = 0; k < 4; k++) s += stim_q[4*w+k];
        exp = avg ? scope_pkg::dat_t'(s >>> 2) : stim_q[4*w+3];  // sum or last
        if (out_q[base+w] !== exp) report_mismatch("sto_dat", out_q[base+w], exp);
      end
    end
    test_done(avg ? "averaging" : "decimation", err0);
  endtask

  task automatic test_sw_trigger();
    int err0, base, lst0, it0, is0, sw0, n;
    logic [31:0] rd, lo, hi;
    logic [63:0] t0, t1;
    err0 = errors;
    sw0  = n_swo;
    setup(1'b0, 4'b0001, 5, 8, 0, 1'b0, 0);
    base = out_q.size();
    lst0 = n_lst;
    it0  = n_irq_trg;
    is0  = n_irq_stp;
    fill_random(5);
    feed_stim();
    n = 0;
    do begin
      bus_read(scope_pkg::reg_sts_pre, rd);
      n++;
    end while (rd != 5 && n < 20);
    if (rd != 5) report_fail("sts_pre never reached 5");
    t0 = cts;
    bus_write(scope_pkg::reg_ctl, 32'h2);
    t1 = cts;
    if (n_swo - sw0 != 1) report_mismatch("trg_swo count", n_swo - sw0, 1);
    fill_random(10);  // two more than post count
    feed_stim();
    if (out_q.size() - base != 13) report_mismatch("sto_vld count", out_q.size() - base, 13);
    else if (lst_q[base+12] !== 1'b1) report_fail("8th post sample lacks sto_lst");
    if (n_lst - lst0 != 1) report_mismatch("sto_lst count", n_lst - lst0, 1);
    if (n_irq_trg - it0 != 1) report_mismatch("irq_trg count", n_irq_trg - it0, 1);
    if (n_irq_stp - is0 != 1) report_mismatch("irq_stp count", n_irq_stp - is0, 1);
    read_expect(scope_pkg::reg_ctl, 32'ha, "ctl status");  // triggered and stopped
    bus_read(scope_pkg::reg_cts_lo, lo);
    bus_read(scope_pkg::reg_cts_hi, hi);
    if ({hi, lo} < t0 || {hi, lo} > t1) report_fail("cts_trg outside trigger write window");
    test_done("software trigger", err0);
  endtask

  task automatic test_edge();
    int err0, tr0, it0;
    err0 = errors;
    bus_write(scope_pkg::reg_lvl, 100);
    bus_write(scope_pkg::reg_hst, 20);  // band 80 .. 120
    bus_write(scope_pkg::reg_edg, 1);   // falling first
    setup(1'b0, 4'b0010, 0, 4, 0, 1'b0, 0);
    tr0 = n_trg;
    stim_q.delete();
    for (int i = 0; i < 12; i++) stim_q.push_back(scope_pkg::dat_t'(40 + 10*i));
    feed_stim();
    if (n_trg != tr0) report_fail("falling edge fired on a rising ramp");
    read_expect(scope_pkg::reg_ctl, 32'h4, "ctl status");  // still acquiring
    bus_write(scope_pkg::reg_edg, 0);
    setup(1'b0, 4'b0010, 0, 4, 0, 1'b0, 0);
    tr0 = n_trg;
    it0 = n_irq_trg;
    stim_q.delete();
    for (int i = 0; i < 5; i++) stim_q.push_back(scope_pkg::dat_t'(100 - 10*i));  // down
    for (int i = 1; i < 8; i++) stim_q.push_back(scope_pkg::dat_t'(60 + 10*i));   // up
    for (int i = 0; i < 6; i++) stim_q.push_back(scope_pkg::dat_t'(i % 2 ? 110 : 90));
    feed_stim();
    if (n_trg - tr0 != 1) report_mismatch("trg_out count", n_trg - tr0, 1);
    if (n_irq_trg - it0 != 1) report_mismatch("irq_trg count", n_irq_trg - it0, 1);
    read_expect(scope_pkg::reg_ctl, 32'ha, "ctl status");
    test_done("edge trigger", err0);
  endtask

  task automatic test_stop_reset();
    int err0, base, lst0, is0;
    err0 = errors;
    setup(1'b1, 4'b0001, 0, 4, 0, 1'b0, 0);
    bus_write(scope_pkg::reg_ctl, 32'h2);  // trigger right away
    base = out_q.size();
    lst0 = n_lst;
    is0  = n_irq_stp;
    fill_random(10);
    feed_stim();
    if (out_q.size() - base != 10) report_mismatch("sto_vld count", out_q.size() - base, 10);
    if (n_lst != lst0) report_fail("sto_lst seen in continuous mode");
    if (n_irq_stp != is0) report_fail("irq_stp before the stop write");
    read_expect(scope_pkg::reg_sts_pst, 32'd10, "sts_pst");
    bus_write(scope_pkg::reg_ctl, 32'h8);
    base = out_q.size();
    feed_stim();  // same samples again and none may pass
    if (n_irq_stp - is0 != 1) report_mismatch("irq_stp count", n_irq_stp - is0, 1);
    if (out_q.size() != base) report_fail("sto_vld high after stop");
    read_expect(scope_pkg::reg_ctl, 32'ha, "ctl status");
    bus_write(scope_pkg::reg_ctl, 32'h1);
    read_expect(scope_pkg::reg_ctl, 32'h8, "ctl status after reset");
    read_expect(scope_pkg::reg_sts_pre, 32'h0, "sts_pre");
    read_expect(scope_pkg::reg_sts_pst, 32'h0, "sts_pst");
    read_expect(scope_pkg::reg_pst, 32'h4, "cfg_pst kept");
    read_expect(scope_pkg::reg_mode, 32'h1, "cfg_con kept");
    test_done("stop and reset", err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    rst       = 1'b1;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    adc_dat   = '0;
    adc_vld   = 1'b0;
    cts       = '0;
    trg_ext   = 2'b00;
    repeat (16) @(posedge bus);
    rst <= 1'b0;
    test_registers();
    test_decimate(1'b0);
    test_decimate(1'b1);
    test_sw_trigger();
    test_edge();
    test_stop_reset();
    $display("%0d tests run, %0d errors", n_tests, errors);
    if (errors == 0) $display("Finished with no errors");
    else $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* scope.f */
hw/scope_pkg.sv
hw/scope_regs.sv
hw/scope_dec_avg.sv
hw/scope_edge.sv
hw/scope_acq.sv
hw/scope_top.sv
tests/scope_tb.sv

/* Makefile */
# Verilator flow for the scope channel testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f scope.f --top-module scope_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f scope.f \
	  --top-module scope_tb -Mdir obj_dir -o scope_sim
	./obj_dir/scope_sim | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
